// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_face_detection
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/cascade_eval.sv
`timescale 1ns/1ns

module cascade_eval (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_start,
  input  frame_pkg::window_s        i_window,
  output cascade_pkg::rom_addr_t    o_addr,
  input  cascade_pkg::classifier_s  i_record,
  output logic                      o_done,
  output logic                      o_is_candidate,
  output frame_pkg::candidate_s     o_candidate
);

  import frame_pkg::*;
  import cascade_pkg::*;

  eval_state_e state_q;
  stage_idx_t  stage_q;
  cls_idx_t    cls_q;
  vote_t       votes_q;
  logic        verdict_q;

  // Window under inspection, held until the next start
  window_s win_q;

  feature_t pos_sum;
  feature_t neg_sum;
  feature_t feature;
  logic     vote;
  logic     stage_pass;
  logic     last_cls;
  logic     last_stage;

  // Masked sums over the latched window
  always_comb
  begin
    pos_sum = '0;
    neg_sum = '0;
    for (int i = 0; i < WINDOW_LENGTH; i++)
    begin
      if (i_record.mask_pos[i])
        pos_sum = pos_sum + feature_t'(win_q.pixels[i]);
      if (i_record.mask_neg[i])
        neg_sum = neg_sum + feature_t'(win_q.pixels[i]);
    end
  end

  assign feature    = pos_sum - neg_sum;
  // Signed compare, feature sign-extends to the threshold width
  assign vote       = (feature > i_record.threshold);
  assign stage_pass = (votes_q >= STAGE_MIN_VOTES[stage_q]);
  assign last_cls   = (cls_q == cls_idx_t'(CLASSIFIERS_PER_STAGE - 1));
  assign last_stage = (stage_q == stage_idx_t'(NUM_STAGES - 1));

  // Stage major address, matches the record order in the ROM
  assign o_addr = {stage_q, cls_q};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q   <= IDLE;
      stage_q   <= '0;
      cls_q     <= '0;
      votes_q   <= '0;
      verdict_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (i_start)
          begin
            state_q   <= FETCH;
            stage_q   <= '0;
            cls_q     <= '0;
            votes_q   <= '0;
            verdict_q <= 1'b0;
          end
        end
        // ROM registers the record this cycle
        FETCH:
        begin
          state_q <= SCORE;
        end
        SCORE:
        begin
          if (vote)
            votes_q <= votes_q + 1'b1;
          if (last_cls)
          begin
            state_q <= STAGE_END;
          end
          else
          begin
            cls_q   <= cls_q + 1'b1;
            state_q <= FETCH;
          end
        end
        STAGE_END:
        begin
          votes_q <= '0;
          cls_q   <= '0;
          // Early reject, remaining stages are skipped
          if (!stage_pass)
          begin
            state_q <= DONE;
          end
          else if (last_stage)
          begin
            verdict_q <= 1'b1;
            state_q   <= DONE;
          end
          else
          begin
            stage_q <= stage_q + 1'b1;
            state_q <= FETCH;
          end
        end
        DONE:
        begin
          state_q <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_start && (state_q == IDLE))
      win_q <= i_window;
  end

  assign o_done         = (state_q == DONE);
  assign o_is_candidate = verdict_q;
  // Result is the coordinate of the newest pixel
  assign o_candidate    = candidate_s'{y: win_q.y, x: win_q.x};

  // Top level holds pixel intake until the verdict is out
  a_start_in_idle: assert property (@(posedge clk) disable iff (reset)
    i_start |-> (state_q == IDLE));

  a_done_single: assert property (@(posedge clk) disable iff (reset)
    o_done |=> !o_done);

endmodule

// File: hw/cascade_pkg.sv
package cascade_pkg;

  // Cascade shape
  localparam int NUM_STAGES            = 2;
  localparam int CLASSIFIERS_PER_STAGE = 4;

  // One record per classifier, stage major
  localparam int ROM_DEPTH  = NUM_STAGES * CLASSIFIERS_PER_STAGE;
  localparam int ROM_ADDR_W = $clog2(ROM_DEPTH);
  localparam ROM_FILE       = "hw/cascade_rom.hex";

  localparam int STAGE_IDX_W = $clog2(NUM_STAGES);
  localparam int CLS_IDX_W   = $clog2(CLASSIFIERS_PER_STAGE);
  // Enough to count every classifier of a stage voting
  localparam int VOTE_W      = $clog2(CLASSIFIERS_PER_STAGE + 1);

  // Votes a stage needs to pass, stage 0 in the low slice
  localparam logic [NUM_STAGES-1:0][VOTE_W-1:0] STAGE_MIN_VOTES = {3'd2, 3'd3};

  typedef logic [ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [STAGE_IDX_W-1:0] stage_idx_t;
  typedef logic [CLS_IDX_W-1:0]   cls_idx_t;
  typedef logic [VOTE_W-1:0]      vote_t;

  // Masked pixel sum difference, 8 x 255 fits with sign
  typedef logic signed [12:0] feature_t;
  typedef logic signed [15:0] threshold_t;
  // Bit i selects window pixel i
  typedef logic [frame_pkg::WINDOW_LENGTH-1:0] mask_t;

  // Hex word layout: mask_pos, mask_neg, threshold
  typedef struct packed {
    mask_t      mask_pos;
    mask_t      mask_neg;
    threshold_t threshold;
  } classifier_s;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    SCORE,
    STAGE_END,
    DONE
  } eval_state_e;

endpackage

// File: hw/cascade_rom.hex
// One classifier per line, 32-bit word: mask_pos[31:24] mask_neg[23:16] threshold[15:0]
// Mask bit i selects window pixel i (0 oldest), threshold is signed
// Stage 0, classifier 0: newer half brighter than older half
F00F0000
// Stage 0, classifier 1: window not nearly black
FF000064
// Stage 0, classifier 2: centre brighter than edges
3CC30000
// Stage 0, classifier 3: edge pixels not both zero
81000000
// Stage 1, classifier 0: overall brightness floor
FF000040
// Stage 1, classifier 1: odd pixels over even pixels
AA550000
// Stage 1, classifier 2: middle pair over its neighbours
18240000
// Stage 1, classifier 3: inner pair against outer pair, loose margin
4281FF80

// File: hw/cascade_rom.sv
`timescale 1ns/1ns

module cascade_rom (
  input  logic                      clk,
  input  cascade_pkg::rom_addr_t    i_addr,
  output cascade_pkg::classifier_s  o_record
);

  import cascade_pkg::*;

  // Raw words, one classifier record each
  logic [$bits(classifier_s)-1:0] rom_mem [ROM_DEPTH];

  classifier_s record_q;

  // Line k is stage k/4, classifier k%4
  initial
  begin
    $readmemh(ROM_FILE, rom_mem);
  end

  // Registered read, record is seen one cycle after the address
  always_ff @(posedge clk)
  begin
    record_q <= classifier_s'(rom_mem[i_addr]);
  end

  assign o_record = record_q;

endmodule

// File: hw/face_detection.sv
`timescale 1ns/1ns

module face_detection (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_pixel_valid,
  input  frame_pkg::pixel_t      i_pixel,
  output logic                   o_ready_pixel,
  output logic                   o_frame_end,
  output logic                   o_result_valid,
  output frame_pkg::candidate_s  o_result_data,
  input  logic                   i_result_pop
);

  import frame_pkg::*;
  import cascade_pkg::*;

  // Pixel intake control
  logic ready_q;
  logic boot_q;

  // Candidate waiting for FIFO space
  logic       pending_q;
  candidate_s pending_data_q;

  window_s window;
  logic    window_valid;
  logic    window_skip;

  rom_addr_t   rom_addr;
  classifier_s rom_record;

  logic       eval_done;
  logic       eval_is_candidate;
  candidate_s eval_candidate;

  logic       fifo_full;
  logic       fifo_write;
  candidate_s fifo_data;

  // Fresh verdict goes straight in when there is room
  assign fifo_write = !fifo_full && (pending_q || (eval_done && eval_is_candidate));
  assign fifo_data  = pending_q ? pending_data_q : eval_candidate;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ready_q   <= 1'b0;
      boot_q    <= 1'b1;
      pending_q <= 1'b0;
    end
    else if (boot_q)
    begin
      // First cycle out of reset
      ready_q <= 1'b1;
      boot_q  <= 1'b0;
    end
    else if (i_pixel_valid)
    begin
      ready_q <= 1'b0;
    end
    else if (window_skip)
    begin
      ready_q <= 1'b1;
    end
    else if (eval_done)
    begin
      // Candidate and no room, intake stays paused
      if (eval_is_candidate && fifo_full)
        pending_q <= 1'b1;
      else
        ready_q <= 1'b1;
    end
    else if (pending_q && !fifo_full)
    begin
      pending_q <= 1'b0;
      ready_q   <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (eval_done && eval_is_candidate && fifo_full)
      pending_data_q <= eval_candidate;
  end

  assign o_ready_pixel = ready_q;

  pixel_window u_pixel_window (
    .clk            (clk),
    .reset          (reset),
    .i_pixel_valid  (i_pixel_valid),
    .i_pixel        (i_pixel),
    .o_window       (window),
    .o_window_valid (window_valid),
    .o_window_skip  (window_skip),
    .o_frame_end    (o_frame_end)
  );

  cascade_rom u_cascade_rom (
    .clk      (clk),
    .i_addr   (rom_addr),
    .o_record (rom_record)
  );

  cascade_eval u_cascade_eval (
    .clk            (clk),
    .reset          (reset),
    .i_start        (window_valid),
    .i_window       (window),
    .o_addr         (rom_addr),
    .i_record       (rom_record),
    .o_done         (eval_done),
    .o_is_candidate (eval_is_candidate),
    .o_candidate    (eval_candidate)
  );

  result_fifo u_result_fifo (
    .clk     (clk),
    .reset   (reset),
    .i_write (fifo_write),
    .i_data  (fifo_data),
    .i_pop   (i_result_pop),
    .o_valid (o_result_valid),
    .o_full  (fifo_full),
    .o_data  (o_result_data)
  );

  // Host only offers a pixel while intake is open
  a_pixel_when_ready: assert property (@(posedge clk) disable iff (reset)
    i_pixel_valid |-> o_ready_pixel);

endmodule

// File: hw/frame_pkg.sv
package frame_pkg;

  // Frame geometry in pixels
  localparam int FRAME_WIDTH  = 32;
  localparam int FRAME_HEIGHT = 8;
  localparam int PIXEL_W      = 8;

  // Pixels per horizontal window
  localparam int WINDOW_LENGTH = 8;

  // Depth of the result FIFO
  localparam int RESULT_DEPTH = 16;
  localparam int RESULT_PTR_W = $clog2(RESULT_DEPTH);

  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [$clog2(FRAME_WIDTH)-1:0] x_t;
  typedef logic [$clog2(FRAME_HEIGHT)-1:0] y_t;

  typedef logic [RESULT_PTR_W-1:0] result_ptr_t;
  // One extra bit so a full store is distinct from an empty one
  typedef logic [RESULT_PTR_W:0] result_count_t;

  // Index 0 is the oldest pixel, x and y belong to the newest
  typedef struct packed {
    pixel_t [WINDOW_LENGTH-1:0] pixels;
    x_t                         x;
    y_t                         y;
  } window_s;

  // Result word, row in the upper bits
  typedef struct packed {
    y_t y;
    x_t x;
  } candidate_s;

endpackage

// File: hw/pixel_window.sv
`timescale 1ns/1ns

module pixel_window (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_pixel_valid,
  input  frame_pkg::pixel_t    i_pixel,
  output frame_pkg::window_s   o_window,
  output logic                 o_window_valid,
  output logic                 o_window_skip,
  output logic                 o_frame_end
);

  import frame_pkg::*;

  // Position of the pixel that arrives next
  x_t x_q;
  y_t y_q;

  logic window_valid_q;
  logic window_skip_q;
  logic frame_end_q;

  logic last_col;
  logic last_row;
  logic full_window;

  // Shift source, empty at the start of a row
  pixel_t [WINDOW_LENGTH-1:0] shift_src;

  window_s window_q;

  assign last_col    = (x_q == x_t'(FRAME_WIDTH - 1));
  assign last_row    = (y_q == y_t'(FRAME_HEIGHT - 1));
  // Enough pixels of this row seen to fill a window
  assign full_window = (x_q >= x_t'(WINDOW_LENGTH - 1));
  assign shift_src   = (x_q == '0) ? '0 : window_q.pixels;

  // Coordinate iterator and per-pixel pulses
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      x_q            <= '0;
      y_q            <= '0;
      window_valid_q <= 1'b0;
      window_skip_q  <= 1'b0;
      frame_end_q    <= 1'b0;
    end
    else
    begin
      window_valid_q <= i_pixel_valid && full_window;
      window_skip_q  <= i_pixel_valid && !full_window;
      frame_end_q    <= i_pixel_valid && last_col && last_row;
      if (i_pixel_valid)
      begin
        if (last_col)
        begin
          x_q <= '0;
          // Wrap to row 0 after the last pixel of the frame
          if (last_row)
            y_q <= '0;
          else
            y_q <= y_q + 1'b1;
        end
        else
        begin
          x_q <= x_q + 1'b1;
        end
      end
    end
  end

  // Newest pixel enters at the top, oldest drops out of index 0
  always_ff @(posedge clk)
  begin
    if (i_pixel_valid)
    begin
      window_q.pixels <= {i_pixel, shift_src[WINDOW_LENGTH-1:1]};
      window_q.x      <= x_q;
      window_q.y      <= y_q;
    end
  end

  assign o_window       = window_q;
  assign o_window_valid = window_valid_q;
  assign o_window_skip  = window_skip_q;
  assign o_frame_end    = frame_end_q;

endmodule

// File: hw/result_fifo.sv
`timescale 1ns/1ns

module result_fifo (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_write,
  input  frame_pkg::candidate_s  i_data,
  input  logic                   i_pop,
  output logic                   o_valid,
  output logic                   o_full,
  output frame_pkg::candidate_s  o_data
);

  import frame_pkg::*;

  candidate_s fifo_mem [RESULT_DEPTH];

  result_ptr_t   wr_ptr_q;
  result_ptr_t   rd_ptr_q;
  result_count_t count_q;

  logic do_write;
  logic do_pop;

  assign o_valid = (count_q != '0);
  assign o_full  = (count_q == result_count_t'(RESULT_DEPTH));

  // Pop on empty is dropped
  assign do_pop   = i_pop && o_valid;
  assign do_write = i_write && !o_full;

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      // Depth is a power of two, pointers wrap on their own
      if (do_write)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_write && !do_pop)
        count_q <= count_q + 1'b1;
      else if (do_pop && !do_write)
        count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_write)
      fifo_mem[wr_ptr_q] <= i_data;
  end

  // Head entry shown while not empty
  assign o_data = fifo_mem[rd_ptr_q];

  // Writer must wait for space
  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    i_write |-> !o_full);

endmodule

// File: sim/tb_face_detection.sv
`timescale 1ns/1ns

module tb_face_detection;

  import frame_pkg::*;
  import cascade_pkg::*;

  localparam int PIXELS_PER_FRAME = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int NUM_FRAMES       = 3;
  localparam int READY_TIMEOUT    = 300;
  localparam int FILL_TIMEOUT     = 3000;
  localparam int RESULT_TIMEOUT   = 300;
  localparam int STALL_CYCLES     = 40;
  localparam     ROM_PATH         = "hw/cascade_rom.hex";

  logic       clk;
  logic       reset;
  logic       i_pixel_valid;
  pixel_t     i_pixel;
  logic       o_ready_pixel;
  logic       o_frame_end;
  logic       o_result_valid;
  candidate_s o_result_data;
  logic       i_result_pop;

  // Reference model state
  logic [31:0] rom_image [8];
  int          min_votes [2] = '{3, 2};
  int          model_win [WINDOW_LENGTH];
  int          model_x = 0;
  int          model_y = 0;
  logic [7:0]  expected_q [$];

  int pixels_sent = 0;
  int frame_ends  = 0;
  bit driver_done = 1'b0;

  face_detection u_dut (
    .clk            (clk),
    .reset          (reset),
    .i_pixel_valid  (i_pixel_valid),
    .i_pixel        (i_pixel),
    .o_ready_pixel  (o_ready_pixel),
    .o_frame_end    (o_frame_end),
    .o_result_valid (o_result_valid),
    .o_result_data  (o_result_data),
    .i_result_pop   (i_result_pop)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Dark, bright or full-range band, equally likely
  function automatic pixel_t random_pixel();
    int band;
    band = $urandom_range(2, 0);
    case (band)
      0: return pixel_t'($urandom_range(31, 0));
      1: return pixel_t'($urandom_range(255, 224));
      default: return pixel_t'($urandom_range(255, 0));
    endcase
  endfunction

  // Every stage must reach its vote count
  function automatic bit window_passes();
    logic [31:0] rec;
    int pos;
    int neg;
    int thr;
    int votes;
    for (int s = 0; s < NUM_STAGES; s++)
    begin
      votes = 0;
      for (int c = 0; c < CLASSIFIERS_PER_STAGE; c++)
      begin
        rec = rom_image[s * CLASSIFIERS_PER_STAGE + c];
        pos = 0;
        neg = 0;
        for (int i = 0; i < WINDOW_LENGTH; i++)
        begin
          if (rec[24 + i])
            pos += model_win[i];
          if (rec[16 + i])
            neg += model_win[i];
        end
        // Threshold field is signed
        thr = int'($signed(rec[15:0]));
        if (pos - neg > thr)
          votes++;
      end
      if (votes < min_votes[s])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  // Window update, verdict and coordinate step for one pixel
  function automatic void model_pixel(input pixel_t pix);
    if (model_x == 0)
    begin
      foreach (model_win[i])
        model_win[i] = 0;
    end
    for (int i = 0; i < WINDOW_LENGTH - 1; i++)
      model_win[i] = model_win[i + 1];
    model_win[WINDOW_LENGTH - 1] = int'(pix);
    if ((model_x >= WINDOW_LENGTH - 1) && window_passes())
      expected_q.push_back({y_t'(model_y), x_t'(model_x)});
    model_x++;
    if (model_x == FRAME_WIDTH)
    begin
      model_x = 0;
      model_y = (model_y + 1) % FRAME_HEIGHT;
    end
  endfunction

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!o_ready_pixel)
    begin
      @(posedge clk);
      #2;
      cycles++;
      assert (cycles < READY_TIMEOUT)
        else report_failure("Timed out waiting for o_ready_pixel");
    end
  endtask

  task automatic drive_frames();
    pixel_t pix;
    for (int n = 0; n < NUM_FRAMES * PIXELS_PER_FRAME; n++)
    begin
      wait_ready();
      pix = random_pixel();
      model_pixel(pix);
      i_pixel       = pix;
      i_pixel_valid = 1'b1;
      pixels_sent++;
      @(posedge clk);
      #2;
      i_pixel_valid = 1'b0;
    end
    // Last verdict is out once intake reopens
    wait_ready();
    driver_done = 1'b1;
  endtask

  // Pops held until one candidate waits behind a full FIFO
  task automatic fill_and_stall();
    int waited;
    i_result_pop = 1'b0;
    waited = 0;
    while (expected_q.size() <= RESULT_DEPTH)
    begin
      @(posedge clk);
      #2;
      waited++;
      assert (waited < FILL_TIMEOUT)
        else report_failure("Result FIFO never filled while popping was paused");
    end
    repeat (STALL_CYCLES)
    begin
      @(posedge clk);
      #2;
      assert (!o_ready_pixel)
        else report_failure("Pixel intake resumed while a candidate waited for FIFO space");
      assert (o_result_valid)
        else report_failure("Result FIFO reported empty while full of candidates");
    end
  endtask

  task automatic pop_results();
    int  next_pause;
    int  starved;
    bit  want_pop;
    next_pause = 0;
    starved    = 0;
    while (!(driver_done && (expected_q.size() == 0)))
    begin
      @(posedge clk);
      #2;
      // One fill pause at the start of each frame
      if (!driver_done && (pixels_sent >= next_pause) &&
          (next_pause < NUM_FRAMES * PIXELS_PER_FRAME))
      begin
        fill_and_stall();
        next_pause += PIXELS_PER_FRAME;
      end
      else
      begin
        // Pops on an empty FIFO are sent too
        want_pop     = 1'($urandom_range(1, 0));
        i_result_pop = want_pop;
        if (want_pop && o_result_valid)
        begin
          assert (expected_q.size() > 0)
            else report_failure("Result appeared that the model did not expect");
          // No window ends before column 7
          assert (o_result_data.x >= x_t'(WINDOW_LENGTH - 1))
            else report_failure($sformatf(
              "CHECK FAILED o_result_data.x got 0x%02h expected >= 0x%02h",
              o_result_data.x, WINDOW_LENGTH - 1));
          assert (o_result_data == expected_q[0])
            else report_failure($sformatf(
              "CHECK FAILED o_result_data got 0x%02h expected 0x%02h",
              o_result_data, expected_q[0]));
          void'(expected_q.pop_front());
        end
        if ((expected_q.size() > 0) && !o_result_valid)
          starved++;
        else
          starved = 0;
        assert (starved < RESULT_TIMEOUT)
          else report_failure("Timed out waiting for an expected result");
      end
    end
  endtask

  // Frame end must land right after each frame's last pixel
  always @(negedge clk)
  begin
    if (!reset && o_frame_end)
    begin
      frame_ends++;
      assert (pixels_sent == frame_ends * PIXELS_PER_FRAME)
        else report_failure($sformatf("o_frame_end pulsed after %0d pixels, off a frame boundary",
                                      pixels_sent));
    end
  end

  initial
  begin
    void'($urandom(32'h685));
    $readmemh(ROM_PATH, rom_image);
    reset         = 1'b1;
    i_pixel_valid = 1'b0;
    i_pixel       = '0;
    i_result_pop  = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    // Quiet outputs straight after reset
    assert (o_result_valid == 1'b0)
      else report_failure($sformatf("CHECK FAILED o_result_valid got 0x%0h expected 0x0",
                                    o_result_valid));
    assert (o_frame_end == 1'b0)
      else report_failure($sformatf("CHECK FAILED o_frame_end got 0x%0h expected 0x0",
                                    o_frame_end));
    wait_ready();

    fork
      drive_frames();
      pop_results();
    join

    // Let the last pop settle
    @(posedge clk);
    #2;
    i_result_pop = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    assert (o_result_valid == 1'b0)
      else report_failure($sformatf("CHECK FAILED o_result_valid got 0x%0h expected 0x0",
                                    o_result_valid));
    assert (expected_q.size() == 0)
      else report_failure("Expected candidates were never delivered");
    assert (frame_ends == NUM_FRAMES)
      else report_failure($sformatf("CHECK FAILED frame_end count got 0x%0h expected 0x%0h",
                                    frame_ends, NUM_FRAMES));

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: sources.f
hw/frame_pkg.sv
hw/cascade_pkg.sv
hw/pixel_window.sv
hw/cascade_rom.sv
hw/cascade_eval.sv
hw/result_fifo.sv
hw/face_detection.sv
sim/tb_face_detection.sv
